/* Makefile */
# Verilator flow for the WISC core

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= wiscCore_tb
RTL_TOP    ?= wiscCore
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+design
design/wiscPkg.sv
design/control.sv
design/regFile.sv
design/decodeStage.sv
design/alu.sv
design/branchUnit.sv
design/dataMem.sv
design/wiscCore.sv
tests/wiscCore_tb.sv

/* design/alu.sv */
// WISC ALU
// Inverting adder for add, subtract and compares
// Logic ops, rotates, shifts, bit reverse and byte loads
`timescale 1ns/10ps
`include "wisc_defines.svh"

module alu
	import wiscPkg::*;
(
	input  opcodeT opcode,
	input  functT  funct,
	input  ctrlT   ctrl,
	input  wordT   a,
	input  wordT   b,
	input  wordT   imm,
	output wordT   result
);

	localparam int W = `WISC_WORD_W;

	wordT opSel, opA, opB, sum, shiftRes, btr;
	logic cout, eq, lt;
	logic [1:0] shiftOp;
	logic [3:0] shamt;
	logic [2*W-1:0] rolWide, rorWide;

	// Operand select and inversion
	assign opSel = ctrl.aluSrc2 ? b : imm;
	assign opA = ctrl.invA ? ~a : a;
	assign opB = ctrl.invB ? ~opSel : opSel;
	assign {cout, sum} = {1'b0, opA} + {1'b0, opB} + {{W{1'b0}}, ctrl.cin};

	// Compares on Rs - Rt, sign taken from a when the signs differ
	assign eq = (sum == '0);
	assign lt = (a[W-1] ^ opSel[W-1]) ? a[W-1] : sum[W-1];

	////////////////////////////////////////////////////////////
	// Rotates and shifts
	assign shiftOp = (opcode == `OP_ALU2) ? funct : opcode[1:0];
	assign shamt = opSel[3:0];
	assign rolWide = {a, a} << shamt;
	assign rorWide = {a, a} >> shamt;

	always_comb begin
		case (shiftOp)
			`FN_ROL: shiftRes = rolWide[2*W-1:W];
			`FN_SLL: shiftRes = a << shamt;
			`FN_ROR: shiftRes = rorWide[W-1:0];
			default: shiftRes = a >> shamt;
		endcase
	end

	always_comb begin
		for (int i = 0; i < W; i++)
			btr[i] = a[W-1-i];
	end

	////////////////////////////////////////////////////////////
	// Result select
	always_comb begin
		case (opcode)
			`OP_ALU1: begin
				if (funct == `FN_XOR)
					result = a ^ opB;
				else if (funct == `FN_ANDN)
					result = a & opB;
				else
					result = sum;
			end
			`OP_XORI:  result = a ^ opB;
			`OP_ANDNI: result = a & opB;
			`OP_ALU2, `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: result = shiftRes;
			`OP_SEQ:   result = {{(W-1){1'b0}}, eq};
			`OP_SLT:   result = {{(W-1){1'b0}}, lt};
			`OP_SLE:   result = {{(W-1){1'b0}}, lt | eq};
			`OP_SCO:   result = {{(W-1){1'b0}}, cout};
			`OP_BTR:   result = btr;
			`OP_LBI:   result = opSel;
			`OP_SLBI:  result = (a << 8) | opSel;
			// ADDI, SUBI and the memory address
			default:   result = sum;
		endcase
	end

endmodule

/* design/branchUnit.sv */
// WISC next-PC unit
// Branch test on Rs, jump targets, trap vector and return from trap
`timescale 1ns/10ps
`include "wisc_defines.svh"

module branchUnit
	import wiscPkg::*;
(
	input  ctrlT   ctrl,
	input  opcodeT opcode,
	input  wordT   pc,
	input  wordT   epc,
	input  wordT   rsVal,
	input  wordT   imm,
	output wordT   nextPc,
	output logic   saveEpc
);

	wordT seqPc, target;
	logic taken;

	assign seqPc = pc + wordT'(2);

	// Low opcode bits give the condition
	always_comb begin
		case (opcode[1:0])
			2'b00:   taken = (rsVal != '0);
			2'b01:   taken = (rsVal == '0);
			2'b10:   taken = rsVal[$bits(wordT)-1];
			default: taken = !rsVal[$bits(wordT)-1];
		endcase
	end

	always_comb begin
		if (ctrl.trap)
			target = `EXC_VECTOR;
		else if (ctrl.rti)
			target = epc;
		else if (ctrl.jump)
			target = rsVal + imm;
		else if (ctrl.pcImm || (ctrl.branching && taken))
			target = seqPc + imm;
		else
			target = seqPc;
	end

	assign nextPc = ctrl.pcSrc ? target : seqPc;
	assign saveEpc = ctrl.trap;

endmodule

/* design/control.sv */
// WISC instruction decoder
// Maps opcode and funct onto the control bundle
// Unknown or undriven encodings raise err
`timescale 1ns/10ps
`include "wisc_defines.svh"

module control
	import wiscPkg::*;
(
	input  opcodeT opcode,
	input  functT  funct,
	output ctrlT   ctrl
);

	logic unknown;

	// X on any decode bit is treated as an illegal encoding
	assign unknown = (^opcode === 1'bx) || (^funct === 1'bx);

	always_comb begin
		// Most instructions write a register from two register operands
		ctrl = '0;
		ctrl.regWrite = 1'b1;
		ctrl.aluSrc2 = 1'b1;
		ctrl.seSel = SE_ZEXT5;
		ctrl.regDst = RD_RD;

		case (opcode)
			////////////////////////////////////////////////////////////
			// R-format, destination in bits 4:2
			`OP_ALU1: begin
				if (funct == `FN_SUB) begin
					// Rt - Rs
					ctrl.invA = 1'b1;
					ctrl.cin = 1'b1;
				end
				if (funct == `FN_ANDN)
					ctrl.invB = 1'b1;
			end
			`OP_ALU2, `OP_BTR, `OP_SCO: begin
				ctrl.regDst = RD_RD;
			end
			`OP_SEQ, `OP_SLT, `OP_SLE: begin
				// Rs - Rt feeds the compares
				ctrl.invB = 1'b1;
				ctrl.cin = 1'b1;
			end

			////////////////////////////////////////////////////////////
			// I-format 1, destination in bits 7:5
			`OP_SUBI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.invA = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.seSel = SE_SEXT5;
				ctrl.regDst = RD_RT;
			end
			`OP_ADDI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.regDst = RD_RT;
			end
			`OP_ANDNI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.invB = 1'b1;
				ctrl.regDst = RD_RT;
			end
			`OP_XORI, `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.regDst = RD_RT;
			end
			`OP_ST: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.regWrite = 1'b0;
				ctrl.dMemEn = 1'b1;
				ctrl.dMemWrite = 1'b1;
			end
			`OP_LD: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.dMemEn = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regDst = RD_RT;
			end
			// Store, then write the address back to Rs
			`OP_STU: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = SE_SEXT5;
				ctrl.dMemEn = 1'b1;
				ctrl.dMemWrite = 1'b1;
				ctrl.regDst = RD_RS;
			end

			////////////////////////////////////////////////////////////
			// I-format 2 and jumps
			`OP_BNEZ, `OP_BEQZ, `OP_BLTZ, `OP_BGEZ: begin
				ctrl.seSel = SE_SEXT8;
				ctrl.regWrite = 1'b0;
				ctrl.pcSrc = 1'b1;
				ctrl.branching = 1'b1;
			end
			`OP_LBI, `OP_SLBI: begin
				ctrl.aluSrc2 = 1'b0;
				ctrl.seSel = (opcode == `OP_LBI) ? SE_SEXT8 : SE_ZEXT8;
				ctrl.regDst = RD_RS;
			end
			`OP_J, `OP_JAL: begin
				ctrl.seSel = SE_SEXT11;
				ctrl.pcSrc = 1'b1;
				ctrl.pcImm = 1'b1;
				// JAL links into R7
				ctrl.regWrite = (opcode == `OP_JAL);
				ctrl.regDst = RD_R7;
			end
			`OP_JR, `OP_JALR: begin
				ctrl.seSel = SE_SEXT8;
				ctrl.pcSrc = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.regWrite = (opcode == `OP_JALR);
				ctrl.regDst = RD_R7;
			end

			// Special
			`OP_SIIC: begin
				ctrl.regWrite = 1'b0;
				ctrl.pcSrc = 1'b1;
				ctrl.trap = 1'b1;
			end
			`OP_RTI: begin
				ctrl.regWrite = 1'b0;
				ctrl.pcSrc = 1'b1;
				ctrl.rti = 1'b1;
			end
			`OP_NOP: ctrl.regWrite = 1'b0;
			`OP_HALT: begin
				ctrl.regWrite = 1'b0;
				ctrl.halt = 1'b1;
			end
			default: begin
				ctrl.regWrite = 1'b0;
				ctrl.err = 1'b1;
			end
		endcase

		if (unknown) begin
			ctrl.regWrite = 1'b0;
			ctrl.err = 1'b1;
		end
	end

endmodule

/* design/dataMem.sv */
// WISC data memory
// Word addressed, clocked write, combinational read
`timescale 1ns/10ps
`include "wisc_defines.svh"

module dataMem
	import wiscPkg::*;
(
	input  logic clk,
	input  logic en,
	input  logic wrEn,
	input  wordT addr,
	input  wordT wrData,
	output wordT rdData
);

	localparam int IDX_W = $clog2(`DMEM_DEPTH);

	wordT mem [`DMEM_DEPTH];
	logic [IDX_W-1:0] wordIdx;

	// Byte address, bit 0 ignored
	assign wordIdx = addr[IDX_W:1];
	assign rdData = en ? mem[wordIdx] : '0;

	always_ff @(posedge clk) begin
		if (en && wrEn)
			mem[wordIdx] <= wrData;
	end

endmodule

/* design/decodeStage.sv */
// WISC decode stage
// Field split, destination select, register reads, immediate extension
`timescale 1ns/10ps
`include "wisc_defines.svh"

module decodeStage
	import wiscPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  wordT   instr,
	input  logic   wrEn,
	input  regIdxT wrIdx,
	input  wordT   wrData,
	output ctrlT   ctrl,
	output wordT   rsVal,
	output wordT   rtVal,
	output wordT   imm,
	output regIdxT dstIdx
);

	localparam int W = `WISC_WORD_W;

	control i_control (
		.opcode(instr[15:11]),
		.funct (instr[1:0]),
		.ctrl  (ctrl)
	);

	// Port A reads Rs, port B reads bits 7:5 (Rt or store data)
	regFile i_regFile (
		.clk   (clk),
		.arstN (arstN),
		.rdIdxA(instr[10:8]),
		.rdIdxB(instr[7:5]),
		.rdA   (rsVal),
		.rdB   (rtVal),
		.wrEn  (wrEn),
		.wrIdx (wrIdx),
		.wrData(wrData)
	);

	always_comb begin
		case (ctrl.regDst)
			RD_RD:   dstIdx = instr[4:2];
			RD_RT:   dstIdx = instr[7:5];
			RD_RS:   dstIdx = instr[10:8];
			default: dstIdx = `LINK_REG;
		endcase
	end

	// Upper two select bits pick the field, bit 0 picks 5 or 8 for zero-extend
	always_comb begin
		case (ctrl.seSel[2:1])
			2'b00:   imm = ctrl.seSel[0] ? {{(W-8){1'b0}}, instr[7:0]}
			                             : {{(W-5){1'b0}}, instr[4:0]};
			2'b01:   imm = {{(W-5){instr[4]}}, instr[4:0]};
			2'b10:   imm = {{(W-8){instr[7]}}, instr[7:0]};
			default: imm = {{(W-11){instr[10]}}, instr[10:0]};
		endcase
	end

endmodule

/* design/regFile.sv */
// WISC register file
// Eight words, two asynchronous reads, one clocked write
`timescale 1ns/10ps

module regFile
	import wiscPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  regIdxT rdIdxA,
	input  regIdxT rdIdxB,
	output wordT   rdA,
	output wordT   rdB,
	input  logic   wrEn,
	input  regIdxT wrIdx,
	input  wordT   wrData
);

	localparam int NUM_REGS = 2 ** $bits(regIdxT);

	wordT regs [NUM_REGS];

	// No bypass, a same-cycle read sees the old value
	assign rdA = regs[rdIdxA];
	assign rdB = regs[rdIdxB];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

endmodule

/* design/wiscCore.sv */
// WISC single-cycle core
// PC, EPC and halt state, write-back select and the registered retire record
`timescale 1ns/10ps
`include "wisc_defines.svh"

module wiscCore
	import wiscPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   instrValid,
	input  wordT   instr,
	output logic   retValid,
	output retireT retire,
	output wordT   pc,
	output logic   halted
);

	ctrlT   ctrl;
	regIdxT dstIdx;
	wordT   rsVal, rtVal, imm, aluRes, memData, wbData, nextPc, pcInc, epc;
	logic   accept, commit, saveEpc;
	retireT retNext;

	// Accepted strobes retire, only legal ones change state
	assign accept = instrValid && !halted;
	assign commit = accept && !ctrl.err;
	assign pcInc = pc + wordT'(2);

	decodeStage i_decodeStage (
		.clk   (clk),
		.arstN (arstN),
		.instr (instr),
		.wrEn  (commit && ctrl.regWrite),
		.wrIdx (dstIdx),
		.wrData(wbData),
		.ctrl  (ctrl),
		.rsVal (rsVal),
		.rtVal (rtVal),
		.imm   (imm),
		.dstIdx(dstIdx)
	);

	alu i_alu (
		.opcode(instr[15:11]),
		.funct (instr[1:0]),
		.ctrl  (ctrl),
		.a     (rsVal),
		.b     (rtVal),
		.imm   (imm),
		.result(aluRes)
	);

	branchUnit i_branchUnit (
		.ctrl   (ctrl),
		.opcode (instr[15:11]),
		.pc     (pc),
		.epc    (epc),
		.rsVal  (rsVal),
		.imm    (imm),
		.nextPc (nextPc),
		.saveEpc(saveEpc)
	);

	dataMem i_dataMem (
		.clk   (clk),
		.en    (ctrl.dMemEn),
		.wrEn  (commit && ctrl.dMemWrite),
		.addr  (aluRes),
		.wrData(rtVal),
		.rdData(memData)
	);

	// Load data, link address for JAL and JALR, otherwise the ALU
	always_comb begin
		if (ctrl.memToReg)
			wbData = memData;
		else if (ctrl.regDst == RD_R7)
			wbData = pcInc;
		else
			wbData = aluRes;
	end

	// An erroring instruction reports the unchanged PC
	always_comb begin
		retNext.regWrite = ctrl.regWrite && !ctrl.err;
		retNext.wbReg = dstIdx;
		retNext.wbData = wbData;
		retNext.nextPc = ctrl.err ? pc : nextPc;
		retNext.err = ctrl.err;
		retNext.halt = ctrl.halt && !ctrl.err;
	end

	////////////////////////////////////////////////////////////
	// Architectural state and retire register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RESET_PC;
			epc <= `RESET_PC;
			halted <= 1'b0;
			retValid <= 1'b0;
			retire <= '0;
		end else begin
			retValid <= accept;
			if (accept)
				retire <= retNext;
			if (commit) begin
				pc <= nextPc;
				// Return address for RTI
				if (saveEpc)
					epc <= pcInc;
				if (ctrl.halt)
					halted <= 1'b1;
			end
		end
	end

endmodule

/* design/wiscPkg.sv */
// WISC shared types
// Word and field vectors, control bundle and retire record
package wiscPkg;
`include "wisc_defines.svh"

	typedef logic [`WISC_WORD_W-1:0] wordT;
	typedef logic [2:0] regIdxT;
	typedef logic [4:0] opcodeT;
	typedef logic [1:0] functT;
	typedef logic [2:0] seSelT;
	typedef logic [1:0] regDstT;

	// Immediate extension select, bit 0 only matters for zero-extend
	localparam seSelT SE_ZEXT5  = 3'b000;
	localparam seSelT SE_ZEXT8  = 3'b001;
	localparam seSelT SE_SEXT5  = 3'b010;
	localparam seSelT SE_SEXT8  = 3'b100;
	localparam seSelT SE_SEXT11 = 3'b110;

	// Destination register select
	localparam regDstT RD_RD = 2'b00;
	localparam regDstT RD_RT = 2'b01;
	localparam regDstT RD_RS = 2'b10;
	localparam regDstT RD_R7 = 2'b11;

	typedef struct packed {
		logic   regWrite;
		logic   dMemWrite;
		logic   dMemEn;
		// Set for register operand, clear for immediate
		logic   aluSrc2;
		logic   invA;
		logic   invB;
		logic   cin;
		logic   pcSrc;
		logic   pcImm;
		logic   branching;
		logic   jump;
		logic   memToReg;
		logic   halt;
		logic   trap;
		logic   rti;
		logic   err;
		seSelT  seSel;
		regDstT regDst;
	} ctrlT;

	typedef struct packed {
		logic   regWrite;
		regIdxT wbReg;
		wordT   wbData;
		wordT   nextPc;
		logic   err;
		logic   halt;
	} retireT;

endpackage

/* design/wisc_defines.svh */
// WISC core constants
// Word width, opcode and funct encodings, reset and trap addresses
`ifndef WISC_DEFINES_SVH
`define WISC_DEFINES_SVH

`define WISC_WORD_W 16

// Special and jump opcodes
`define OP_HALT  5'b00000
`define OP_NOP   5'b00001
`define OP_SIIC  5'b00010
`define OP_RTI   5'b00011
`define OP_J     5'b00100
`define OP_JR    5'b00101
`define OP_JAL   5'b00110
`define OP_JALR  5'b00111
// Immediate arithmetic and logic
`define OP_SUBI  5'b01000
`define OP_ADDI  5'b01001
`define OP_ANDNI 5'b01010
`define OP_XORI  5'b01011
// Branches on Rs
`define OP_BNEZ  5'b01100
`define OP_BEQZ  5'b01101
`define OP_BLTZ  5'b01110
`define OP_BGEZ  5'b01111
// Memory and byte loads
`define OP_ST    5'b10000
`define OP_LD    5'b10001
`define OP_SLBI  5'b10010
`define OP_STU   5'b10011
// Immediate rotates and shifts, low bits match the ALU2 funct
`define OP_ROLI  5'b10100
`define OP_SLLI  5'b10101
`define OP_RORI  5'b10110
`define OP_SRLI  5'b10111
`define OP_LBI   5'b11000
`define OP_BTR   5'b11001
`define OP_ALU2  5'b11010
`define OP_ALU1  5'b11011
`define OP_SEQ   5'b11100
`define OP_SLT   5'b11101
`define OP_SLE   5'b11110
`define OP_SCO   5'b11111

// ALU1 group funct
`define FN_ADD  2'b00
`define FN_SUB  2'b01
`define FN_XOR  2'b10
`define FN_ANDN 2'b11
// ALU2 group funct
`define FN_ROL  2'b00
`define FN_SLL  2'b01
`define FN_ROR  2'b10
`define FN_SRL  2'b11

`define RESET_PC   16'h0000
`define EXC_VECTOR 16'h0002
`define LINK_REG   3'd7
`define DMEM_DEPTH 256

`endif

/* tests/wiscCore_tb.sv */
// WISC core testbench
// Random operands run through an ISA reference model with one retire check per strobe
// Covers ALU, memory, branches, jumps, trap and return, illegal encodings and halt
`timescale 1ns/10ps
`include "wisc_defines.svh"

module wiscCore_tb
	import wiscPkg::*;
();

	localparam int NUM_ROUNDS = 4;
	localparam int NUM_MEM = 4;
	// Loads, ALU rounds, memory, branches, jumps, trap, illegal sweep, halt
	localparam int NUM_STROBES = (NUM_ROUNDS + 2) * 16 + NUM_ROUNDS * 22 + NUM_MEM * 4
		+ 15 + 4 + 4 + 9 + 4;
	localparam int CYCLE_LIMIT = 4 * NUM_STROBES + 50;

	logic   clk;
	logic   arstN;
	logic   instrValid;
	wordT   instr;
	logic   retValid;
	retireT retire;
	wordT   pc;
	logic   halted;

	// Reference model state
	wordT   mRegs [8];
	wordT   mMem [`DMEM_DEPTH];
	wordT   mPc;
	wordT   mEpc;
	logic   mHalted;
	retireT expRet;
	wordT   curInstr;

	int unsigned lcgState = 33162;
	int cycleCount = 0;
	logic xProbe;
	logic fourState;

	wiscCore i_dut (
		.clk       (clk),
		.arstN     (arstN),
		.instrValid(instrValid),
		.instr     (instr),
		.retValid  (retValid),
		.retire    (retire),
		.pc        (pc),
		.halted    (halted)
	);

	always #20 clk = ~clk;

	// Hung run guard
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic wordT nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	function automatic wordT encR(opcodeT op, regIdxT rs, regIdxT rt, regIdxT rd, functT fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic wordT encI1(opcodeT op, regIdxT rs, regIdxT rt, logic [4:0] i);
		return {op, rs, rt, i};
	endfunction

	function automatic wordT encI2(opcodeT op, regIdxT rs, logic [7:0] i);
		return {op, rs, i};
	endfunction

	function automatic wordT encJ(opcodeT op, logic [10:0] i);
		return {op, i};
	endfunction

	// Rotate or shift by 0..15 with kind in the ALU2 funct coding
	function automatic wordT shiftRef(logic [1:0] kind, wordT v, logic [3:0] n);
		case (kind)
			`FN_ROL: return (v << n) | (v >> (16 - int'(n)));
			`FN_SLL: return v << n;
			`FN_ROR: return (v >> n) | (v << (16 - int'(n)));
			default: return v >> n;
		endcase
	endfunction

	task automatic abortWithError(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input string what, input wordT got, input wordT want);
		assert (got === want)
		else abortWithError($sformatf("instr %h: %s is %h, expected %h",
			curInstr, what, got, want));
	endtask

	task automatic setWrite(input regIdxT idx, input wordT val);
		expRet.regWrite = 1'b1;
		expRet.wbReg = idx;
		expRet.wbData = val;
		mRegs[idx] = val;
	endtask

	////////////////////////////////////////////////////////////
	// ISA model that sets the expected retire and commits to the model state
	task automatic predict(input wordT w);
		opcodeT op;
		regIdxT rs, rt, rd;
		wordT a, b, imm5s, imm5z, imm8s, imm11s, seqPc, addr, res;
		logic [16:0] wide;
		op = w[15:11];
		rs = w[10:8];
		rt = w[7:5];
		rd = w[4:2];
		a = mRegs[rs];
		b = mRegs[rt];
		imm5s = {{11{w[4]}}, w[4:0]};
		imm5z = {11'd0, w[4:0]};
		imm8s = {{8{w[7]}}, w[7:0]};
		imm11s = {{5{w[10]}}, w[10:0]};
		seqPc = mPc + 16'd2;
		addr = a + imm5s;
		curInstr = w;
		expRet = '0;
		expRet.nextPc = seqPc;
		case (op)
			`OP_ALU1: begin
				case (w[1:0])
					`FN_ADD: res = a + b;
					`FN_SUB: res = b - a;
					`FN_XOR: res = a ^ b;
					default: res = a & ~b;
				endcase
				setWrite(rd, res);
			end
			`OP_ALU2: setWrite(rd, shiftRef(w[1:0], a, b[3:0]));
			`OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: setWrite(rt, shiftRef(op[1:0], a, w[3:0]));
			`OP_SUBI:  setWrite(rt, imm5s - a);
			`OP_ADDI:  setWrite(rt, a + imm5s);
			`OP_ANDNI: setWrite(rt, a & ~imm5z);
			`OP_XORI:  setWrite(rt, a ^ imm5z);
			// Compares are signed
			`OP_SEQ: setWrite(rd, wordT'(a == b));
			`OP_SLT: setWrite(rd, wordT'($signed(a) < $signed(b)));
			`OP_SLE: setWrite(rd, wordT'($signed(a) <= $signed(b)));
			`OP_SCO: begin
				wide = {1'b0, a} + {1'b0, b};
				setWrite(rd, wordT'(wide[16]));
			end
			// Shift the low bits of Rs in from the bottom
			`OP_BTR: begin
				for (int i = 0; i < 16; i++)
					res = {res[14:0], a[i]};
				setWrite(rd, res);
			end
			`OP_LBI:  setWrite(rs, imm8s);
			`OP_SLBI: setWrite(rs, {a[7:0], w[7:0]});
			// Memory is word addressed and drops address bit 0
			`OP_ST: mMem[addr[8:1]] = b;
			`OP_STU: begin
				mMem[addr[8:1]] = b;
				setWrite(rs, addr);
			end
			`OP_LD: setWrite(rt, mMem[addr[8:1]]);
			`OP_BNEZ: if (a != 16'd0) expRet.nextPc = seqPc + imm8s;
			`OP_BEQZ: if (a == 16'd0) expRet.nextPc = seqPc + imm8s;
			`OP_BLTZ: if (a[15]) expRet.nextPc = seqPc + imm8s;
			`OP_BGEZ: if (!a[15]) expRet.nextPc = seqPc + imm8s;
			`OP_J: expRet.nextPc = seqPc + imm11s;
			`OP_JAL: begin
				expRet.nextPc = seqPc + imm11s;
				setWrite(`LINK_REG, seqPc);
			end
			`OP_JR: expRet.nextPc = a + imm8s;
			`OP_JALR: begin
				expRet.nextPc = a + imm8s;
				setWrite(`LINK_REG, seqPc);
			end
			`OP_SIIC: begin
				expRet.nextPc = `EXC_VECTOR;
				mEpc = seqPc;
			end
			`OP_RTI: expRet.nextPc = mEpc;
			`OP_HALT: begin
				expRet.halt = 1'b1;
				mHalted = 1'b1;
			end
			default: ;
		endcase
		mPc = expRet.nextPc;
	endtask

	////////////////////////////////////////////////////////////
	// Strobe and check tasks enter and leave on a falling edge

	task automatic checkRetire();
		assert (retValid === 1'b1)
		else abortWithError($sformatf("instr %h: no retire one cycle after the strobe",
			curInstr));
		checkWord("regWrite", wordT'(retire.regWrite), wordT'(expRet.regWrite));
		if (expRet.regWrite) begin
			checkWord("wbReg", wordT'(retire.wbReg), wordT'(expRet.wbReg));
			checkWord("wbData", retire.wbData, expRet.wbData);
		end
		checkWord("nextPc", retire.nextPc, expRet.nextPc);
		checkWord("err", wordT'(retire.err), wordT'(expRet.err));
		checkWord("halt", wordT'(retire.halt), wordT'(expRet.halt));
		checkWord("pc", pc, expRet.nextPc);
		checkWord("halted", wordT'(halted), wordT'(mHalted));
	endtask

	task automatic issue(input wordT w);
		instrValid = 1'b1;
		instr = w;
		predict(w);
		@(negedge clk);
		checkRetire();
	endtask

	// Every opcode is defined, so only X bits reach the err path
	task automatic issueIllegal();
		instrValid = 1'b1;
		instr = {5'bxxxxx, 11'd0};
		curInstr = instr;
		expRet = '0;
		expRet.err = 1'b1;
		expRet.nextPc = mPc;
		@(negedge clk);
		checkRetire();
	endtask

	task automatic idleCycle();
		instrValid = 1'b0;
		instr = '0;
		@(negedge clk);
		assert (retValid === 1'b0) else abortWithError("retValid high without a strobe");
	endtask

	task automatic strobeWhileHalted(input wordT w);
		instrValid = 1'b1;
		instr = w;
		curInstr = w;
		@(negedge clk);
		assert (retValid === 1'b0) else abortWithError("retire produced while halted");
		checkWord("pc while halted", pc, mPc);
		checkWord("halted", wordT'(halted), 16'd1);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus groups

	// LBI then SLBI builds a full random word in each register
	task automatic loadOperands();
		wordT v;
		for (int r = 0; r < 8; r++) begin
			v = nextRand();
			issue(encI2(`OP_LBI, regIdxT'(r), v[15:8]));
			issue(encI2(`OP_SLBI, regIdxT'(r), v[7:0]));
		end
	endtask

	task automatic aluRound();
		opcodeT rOps [5];
		opcodeT iOps [8];
		wordT r;
		rOps = '{`OP_SEQ, `OP_SLT, `OP_SLE, `OP_SCO, `OP_BTR};
		iOps = '{`OP_SUBI, `OP_ADDI, `OP_ANDNI, `OP_XORI,
			`OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI};
		for (int f = 0; f < 4; f++) begin
			r = nextRand();
			issue(encR(`OP_ALU1, r[2:0], r[5:3], r[8:6], functT'(f)));
			r = nextRand();
			issue(encR(`OP_ALU2, r[2:0], r[5:3], r[8:6], functT'(f)));
		end
		for (int k = 0; k < 5; k++) begin
			r = nextRand();
			issue(encR(rOps[k], r[2:0], r[5:3], r[8:6], 2'b00));
		end
		// Same register twice gives an equal compare
		r = nextRand();
		issue(encR(`OP_SEQ, r[2:0], r[2:0], r[8:6], 2'b00));
		for (int k = 0; k < 8; k++) begin
			r = nextRand();
			issue(encI1(iOps[k], r[2:0], r[5:3], r[13:9]));
		end
	endtask

	task automatic memRound();
		wordT r, s;
		r = nextRand();
		s = nextRand();
		issue(encI1(`OP_ST, r[2:0], r[5:3], r[13:9]));
		issue(encI1(`OP_LD, r[2:0], r[8:6], r[13:9]));
		// Read back at the address left in Rs
		issue(encI1(`OP_STU, s[2:0], s[5:3], s[13:9]));
		issue(encI1(`OP_LD, s[2:0], s[8:6], 5'd0));
	endtask

	task automatic branchTests();
		opcodeT brOps [4];
		wordT r;
		brOps = '{`OP_BNEZ, `OP_BEQZ, `OP_BLTZ, `OP_BGEZ};
		// R1 zero, R2 negative, R3 positive
		issue(encI2(`OP_LBI, 3'd1, 8'h00));
		issue(encI2(`OP_LBI, 3'd2, 8'h85));
		issue(encI2(`OP_LBI, 3'd3, 8'h21));
		for (int b = 0; b < 4; b++) begin
			for (int s = 1; s < 4; s++) begin
				r = nextRand();
				issue(encI2(brOps[b], regIdxT'(s), {r[6:0], 1'b0}));
			end
		end
	endtask

	task automatic jumpTests();
		wordT r;
		loadOperands();
		r = nextRand();
		issue(encJ(`OP_J, {r[10:1], 1'b0}));
		r = nextRand();
		issue(encJ(`OP_JAL, {r[10:1], 1'b0}));
		r = nextRand();
		issue(encI2(`OP_JR, r[2:0], {r[10:4], 1'b0}));
		r = nextRand();
		issue(encI2(`OP_JALR, r[2:0], {r[10:4], 1'b0}));
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		// A two-state simulator cannot carry the X bits of an illegal encoding
		xProbe = 1'bx;
		fourState = (xProbe !== 1'b0) && (xProbe !== 1'b1);
		for (int i = 0; i < 8; i++)
			mRegs[i] = '0;
		mPc = `RESET_PC;
		mEpc = `RESET_PC;
		mHalted = 1'b0;
		curInstr = '0;

		repeat (3) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		assert (retValid === 1'b0) else abortWithError("retValid high after reset");
		assert (retire === '0) else abortWithError("retire record not cleared by reset");
		checkWord("pc after reset", pc, `RESET_PC);
		checkWord("halted after reset", wordT'(halted), 16'd0);
		idleCycle();

		for (int n = 0; n < NUM_ROUNDS; n++) begin
			loadOperands();
			aluRound();
		end
		idleCycle();

		loadOperands();
		for (int m = 0; m < NUM_MEM; m++)
			memRound();
		idleCycle();

		branchTests();
		jumpTests();
		idleCycle();

		// Trap, two fillers, then return past the siic
		issue(encJ(`OP_SIIC, 11'd0));
		issue(encI1(`OP_ADDI, 3'd4, 3'd5, 5'd3));
		issue(encJ(`OP_NOP, 11'd0));
		issue(encJ(`OP_RTI, 11'd0));
		idleCycle();

		if (fourState) begin
			issueIllegal();
			// ADDI r, r, 0 reads every register back
			for (int r = 0; r < 8; r++)
				issue(encI1(`OP_ADDI, regIdxT'(r), regIdxT'(r), 5'd0));
		end else begin
			$display("Note: two-state simulator, illegal encoding check skipped");
		end

		issue(encJ(`OP_HALT, 11'd0));
		for (int k = 0; k < 3; k++)
			strobeWhileHalted(encR(`OP_ALU1, 3'd1, 3'd2, 3'd3, `FN_ADD));
		idleCycle();

		$display("TEST PASSED");
		$finish;
	end

endmodule
